// ==== hdl/cpuPkg.sv ====
// Widths are fixed by the 16-bit instruction set; opcodes not listed below execute as no-ops
package cpuPkg;

  ////////////////////
  // Vector types
  ////////////////////
  typedef logic [15:0] word_t;   // Data word and byte address
  typedef logic [3:0]  regId_t;  // Register number
  typedef logic [3:0]  opcode_t; // Opcode field in bits 15:12
  typedef logic [3:0]  cond_t;   // Branch condition, carried in the rd field
  typedef logic [1:0]  flags_t;  // Z in bit 1, N in bit 0

  ////////////////////
  // Opcodes
  ////////////////////
  localparam opcode_t OP_ADD  = 4'h0;
  localparam opcode_t OP_SUB  = 4'h1;
  localparam opcode_t OP_AND  = 4'h2; // Sets Z only
  localparam opcode_t OP_XOR  = 4'h3; // Sets Z only
  localparam opcode_t OP_ADDI = 4'h4; // Immediate in the rt field
  localparam opcode_t OP_LW   = 4'h8;
  localparam opcode_t OP_SW   = 4'h9; // Stores the rd register
  localparam opcode_t OP_LLI  = 4'hA; // 8-bit immediate, sign-extended
  localparam opcode_t OP_B    = 4'hC;
  localparam opcode_t OP_PCS  = 4'hD;
  localparam opcode_t OP_HLT  = 4'hF;

  ////////////////////
  // Branch conditions
  ////////////////////
  localparam cond_t COND_EQ = 4'h0; // Z set
  localparam cond_t COND_NE = 4'h1; // Z clear
  localparam cond_t COND_LT = 4'h2; // N set
  localparam cond_t COND_AL = 4'h3; // Unconditional

  // First fetch address after reset
  localparam word_t RESET_PC = 16'h0000;

endpackage

// ==== hdl/pipeIf.sv ====
// Pipeline registers only; every field is driven from one side's always_ff and carries no handshake
`timescale 1ns/1ps

// ID/EX register contents
interface decodeExecIf import cpuPkg::*; ();
  logic    valid;     // Entry holds a real instruction
  regId_t  src1;      // Register behind opA, zero when unused
  regId_t  src2;      // Register behind opB and storeData
  regId_t  rd;
  word_t   opA;
  word_t   opB;
  word_t   storeData; // SW data, read from the rd register
  opcode_t aluOp;
  logic    useImm;    // Second ALU input is imm
  word_t   imm;
  logic    regWrite;
  logic    setsZ;
  logic    setsN;
  logic    memEn;
  logic    memWr;
  logic    isHalt;
  logic    isLink;    // PCS
  word_t   linkPc;    // PC+2 of this instruction

  modport src (output valid, src1, src2, rd, opA, opB, storeData, aluOp, useImm, imm,
               regWrite, setsZ, setsN, memEn, memWr, isHalt, isLink, linkPc);
  modport dst (input valid, src1, src2, rd, opA, opB, storeData, aluOp, useImm, imm,
               regWrite, setsZ, setsN, memEn, memWr, isHalt, isLink, linkPc);
  modport mon (input valid, rd, memEn, memWr, setsZ, setsN); // Hazard checks only
endinterface

// EX/MEM register contents
interface execMemIf import cpuPkg::*; ();
  word_t  result;    // ALU result, also the data address
  word_t  storeData;
  regId_t rd;
  logic   regWrite;
  logic   memEn;
  logic   memWr;
  logic   isHalt;
  logic   isLink;
  word_t  linkPc;

  modport src (output result, storeData, rd, regWrite, memEn, memWr, isHalt, isLink, linkPc);
  modport dst (input result, storeData, rd, regWrite, memEn, memWr, isHalt, isLink, linkPc);
endinterface

// ==== hdl/fetchUnit.sv ====
// Predicts not-taken; once HLT is decoded the PC stays frozen and no fetch is valid until reset
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  stall,    // Hold PC and IF/ID
  input  logic  redirect, // Taken branch in decode
  input  word_t target,
  input  logic  haltSeen, // HLT in decode this cycle
  input  word_t inst,     // Instruction at pc, same cycle
  output word_t pc,
  output word_t ifInst,
  output word_t ifPcNext,
  output logic  ifValid
);

  logic  halted; // Sticky after HLT decode
  word_t pcPlus2;

  assign pcPlus2 = pc + 16'd2;

  ////////////////////
  // PC and control
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= RESET_PC;
      ifValid <= 1'b0;
      halted  <= 1'b0;
    end else if (halted || haltSeen) begin
      halted  <= 1'b1;    // Freeze PC, keep IF/ID empty
      ifValid <= 1'b0;
    end else if (redirect) begin
      pc      <= target;
      ifValid <= 1'b0;    // Wrong-path slot becomes a bubble
    end else if (!stall) begin
      pc      <= pcPlus2;
      ifValid <= 1'b1;
    end
  end

  // IF/ID payload, loads with the valid bit
  always_ff @(posedge clk) begin
    if (!stall) begin
      ifInst   <= inst;
      ifPcNext <= pcPlus2; // Link value and branch base
    end
  end

endmodule

// ==== hdl/regFile.sv ====
// Two read ports, one write port; r0 is hardwired to zero and reset clears all registers
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  regId_t rdA,
  input  regId_t rdB,
  input  logic   wbWrite,
  input  regId_t wbRd,
  input  word_t  wbData,
  output word_t  dataA,
  output word_t  dataB
);

  word_t regs [16];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wbWrite && wbRd != '0) begin
      regs[wbRd] <= wbData;
    end
  end

  // Same-cycle write is seen by the reader
  assign dataA = (rdA == '0) ? '0 : (wbWrite && wbRd == rdA) ? wbData : regs[rdA];
  assign dataB = (rdB == '0) ? '0 : (wbWrite && wbRd == rdB) ? wbData : regs[rdB];

endmodule

// ==== hdl/decodeUnit.sv ====
// Branches resolve here against the flag register; sources read as r0 when an opcode does not use them
`timescale 1ns/1ps

module decodeUnit import cpuPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        bubble,   // Hazard stall, ID/EX gets a bubble
  input  word_t       ifInst,
  input  word_t       ifPcNext,
  input  logic        ifValid,
  input  flags_t      flags,
  input  logic        wbWrite,
  input  regId_t      wbRd,
  input  word_t       wbData,
  output logic        redirect,
  output word_t       target,
  output logic        haltSeen,
  output logic        isBranch,
  output regId_t      srcA,
  output regId_t      srcB,
  decodeExecIf.src    idEx
);

  opcode_t op;
  regId_t  rd, rs, rt;
  word_t   imm4, imm8, dataA, dataB;
  logic    useA, useB, bFromRd, condTrue;
  opcode_t aluOp;
  logic    useImm, regWrite, setsZ, setsN, memEn, memWr, isHalt, isLink;
  word_t   imm;

  assign op   = ifInst[15:12];
  assign rd   = ifInst[11:8];
  assign rs   = ifInst[7:4];
  assign rt   = ifInst[3:0];
  assign imm4 = {{12{ifInst[3]}}, ifInst[3:0]};
  assign imm8 = {{8{ifInst[7]}}, ifInst[7:0]};

  ////////////////////
  // Control decode
  ////////////////////
  always_comb begin
    useA = 1'b0; useB = 1'b0; bFromRd = 1'b0;
    aluOp = OP_ADD; useImm = 1'b0; imm = imm4;
    regWrite = 1'b0; setsZ = 1'b0; setsN = 1'b0;
    memEn = 1'b0; memWr = 1'b0; isHalt = 1'b0; isLink = 1'b0;
    case (op)
      OP_ADD, OP_SUB: begin
        useA = 1'b1; useB = 1'b1; aluOp = op;
        regWrite = 1'b1; setsZ = 1'b1; setsN = 1'b1;
      end
      OP_AND, OP_XOR: begin
        useA = 1'b1; useB = 1'b1; aluOp = op;
        regWrite = 1'b1; setsZ = 1'b1;
      end
      OP_ADDI: begin
        useA = 1'b1; useImm = 1'b1;
        regWrite = 1'b1; setsZ = 1'b1; setsN = 1'b1;
      end
      OP_LW: begin
        useA = 1'b1; useImm = 1'b1; regWrite = 1'b1; memEn = 1'b1;
      end
      OP_SW: begin
        useA = 1'b1; useB = 1'b1; bFromRd = 1'b1; // Store data comes from rd
        useImm = 1'b1; memEn = 1'b1; memWr = 1'b1;
      end
      OP_LLI: begin
        useImm = 1'b1; imm = imm8; regWrite = 1'b1; // r0 + imm8
      end
      OP_PCS: begin
        regWrite = 1'b1; isLink = 1'b1;
      end
      OP_HLT:  isHalt = 1'b1;
      default: ;                                   // B and unused opcodes
    endcase
  end

  assign srcA = useA ? rs : '0;
  assign srcB = useB ? (bFromRd ? rd : rt) : '0;

  regFile iRegFile (
    .clk(clk), .rst(rst),
    .rdA(srcA), .rdB(srcB),
    .wbWrite(wbWrite), .wbRd(wbRd), .wbData(wbData),
    .dataA(dataA), .dataB(dataB)
  );

  ////////////////////
  // Branch resolve
  ////////////////////
  always_comb begin
    case (cond_t'(rd))
      COND_EQ: condTrue = flags[1];
      COND_NE: condTrue = !flags[1];
      COND_LT: condTrue = flags[0];
      COND_AL: condTrue = 1'b1;
      default: condTrue = 1'b0;
    endcase
  end

  assign isBranch = ifValid && (op == OP_B);
  assign target   = ifPcNext + {imm8[14:0], 1'b0}; // Offset counts words
  assign redirect = isBranch && condTrue && !bubble; // Waits out a flag stall
  assign haltSeen = ifValid && (op == OP_HLT) && !bubble;

  ////////////////////
  // ID/EX register
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst || bubble || !ifValid) begin
      idEx.valid    <= 1'b0;
      idEx.regWrite <= 1'b0;
      idEx.setsZ    <= 1'b0;
      idEx.setsN    <= 1'b0;
      idEx.memEn    <= 1'b0;
      idEx.memWr    <= 1'b0;
      idEx.isHalt   <= 1'b0;
      idEx.isLink   <= 1'b0;
    end else begin
      idEx.valid    <= 1'b1;
      idEx.regWrite <= regWrite;
      idEx.setsZ    <= setsZ;
      idEx.setsN    <= setsN;
      idEx.memEn    <= memEn;
      idEx.memWr    <= memWr;
      idEx.isHalt   <= isHalt;
      idEx.isLink   <= isLink;
    end
  end

  // Payload, meaningful only with valid
  always_ff @(posedge clk) begin
    idEx.src1      <= srcA;
    idEx.src2      <= srcB;
    idEx.rd        <= rd;
    idEx.opA       <= dataA;
    idEx.opB       <= dataB;
    idEx.storeData <= dataB;
    idEx.aluOp     <= aluOp;
    idEx.useImm    <= useImm;
    idEx.imm       <= imm;
    idEx.linkPc    <= ifPcNext;
  end

endmodule

// ==== hdl/hazardUnit.sv ====
// One-cycle stalls only; loads into r0 never stall, since r0 is never a real source
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*; (
  input  regId_t        srcA,
  input  regId_t        srcB,
  input  logic          isBranch,
  input  logic          ifValid,
  decodeExecIf.mon      idEx,
  output logic          stall,
  output logic          bubble
);

  logic loadHit; // Load in ID/EX feeds decode
  logic flagHit; // Branch needs flags still in EX

  assign loadHit = idEx.valid && idEx.memEn && !idEx.memWr && (idEx.rd != '0) &&
                   ((idEx.rd == srcA) || (idEx.rd == srcB));
  assign flagHit = isBranch && idEx.valid && (idEx.setsZ || idEx.setsN);

  // Hold PC and IF/ID, bubble into ID/EX
  assign stall  = ifValid && (loadHit || flagHit);
  assign bubble = stall;

endmodule

// ==== hdl/executeUnit.sv ====
// EX/MEM forwards ALU results only; a PCS result reaches its consumer through MEM/WB or the register file
`timescale 1ns/1ps

module executeUnit import cpuPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        wbWrite,
  input  regId_t      wbRd,
  input  word_t       wbData,
  decodeExecIf.dst    idEx,
  execMemIf.src       exMem,
  output flags_t      flags   // Z in bit 1, N in bit 0
);

  logic  exOk;                // EX/MEM may forward
  word_t fwdA, fwdB, fwdStore;
  word_t aluB, aluOut;

  // Newest value wins, EX/MEM then MEM/WB then the register read
  function automatic word_t pick(regId_t src, word_t regVal, logic exFwd, regId_t exRd,
                                 word_t exVal, logic wbFwd, regId_t wbR, word_t wbVal);
    if (src != '0 && exFwd && exRd == src) return exVal;
    if (src != '0 && wbFwd && wbR == src) return wbVal;
    return regVal;
  endfunction

  assign exOk = exMem.regWrite && !exMem.memEn && !exMem.isLink;

  ////////////////////
  // Forwarding
  ////////////////////
  assign fwdA     = pick(idEx.src1, idEx.opA, exOk, exMem.rd, exMem.result,
                         wbWrite, wbRd, wbData);
  assign fwdB     = pick(idEx.src2, idEx.opB, exOk, exMem.rd, exMem.result,
                         wbWrite, wbRd, wbData);
  assign fwdStore = pick(idEx.src2, idEx.storeData, exOk, exMem.rd, exMem.result,
                         wbWrite, wbRd, wbData);

  ////////////////////
  // ALU
  ////////////////////
  assign aluB = idEx.useImm ? idEx.imm : fwdB;

  always_comb begin
    case (idEx.aluOp)
      OP_SUB:  aluOut = fwdA - aluB;
      OP_AND:  aluOut = fwdA & aluB;
      OP_XOR:  aluOut = fwdA ^ aluB;
      default: aluOut = fwdA + aluB; // ADD, ADDI, LW/SW address, LLI
    endcase
  end

  // Flag register, read by branches in decode
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (idEx.valid) begin
      if (idEx.setsZ) flags[1] <= (aluOut == '0);
      if (idEx.setsN) flags[0] <= aluOut[15];
    end
  end

  ////////////////////
  // EX/MEM register
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst || !idEx.valid) begin
      exMem.regWrite <= 1'b0;
      exMem.memEn    <= 1'b0;
      exMem.memWr    <= 1'b0;
      exMem.isHalt   <= 1'b0;
      exMem.isLink   <= 1'b0;
    end else begin
      exMem.regWrite <= idEx.regWrite;
      exMem.memEn    <= idEx.memEn;
      exMem.memWr    <= idEx.memWr;
      exMem.isHalt   <= idEx.isHalt;
      exMem.isLink   <= idEx.isLink;
    end
  end

  always_ff @(posedge clk) begin
    exMem.result    <= aluOut;
    exMem.storeData <= fwdStore;
    exMem.rd        <= idEx.rd;
    exMem.linkPc    <= idEx.linkPc;
  end

endmodule

// ==== hdl/memAccessUnit.sv ====
// Data memory must answer in the same cycle; hlt stays high until reset
`timescale 1ns/1ps

module memAccessUnit import cpuPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  word_t    dataRdData,
  execMemIf.dst    exMem,
  output word_t    dataAddr,
  output word_t    dataWrData,
  output logic     dataEn,
  output logic     dataWr,
  output logic     wbWrite,
  output regId_t   wbRd,
  output word_t    wbData,
  output logic     hlt
);

  logic  wbLoad;     // Write back loaded data
  logic  wbLink;     // Write back PC+2
  word_t wbLoadData;
  word_t wbResult;
  word_t wbLinkPc;

  // Data bus straight from EX/MEM
  assign dataAddr   = exMem.result;
  assign dataWrData = exMem.storeData;
  assign dataEn     = exMem.memEn;
  assign dataWr     = exMem.memWr;  // Store commits at the next edge

  ////////////////////
  // MEM/WB register
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      wbWrite <= 1'b0;
      wbLoad  <= 1'b0;
      wbLink  <= 1'b0;
      hlt     <= 1'b0;
    end else begin
      wbWrite <= exMem.regWrite;
      wbLoad  <= exMem.memEn && !exMem.memWr;
      wbLink  <= exMem.isLink;
      hlt     <= hlt || exMem.isHalt; // Rises as HLT enters MEM/WB
    end
  end

  always_ff @(posedge clk) begin
    wbRd       <= exMem.rd;
    wbLoadData <= dataRdData;
    wbResult   <= exMem.result;
    wbLinkPc   <= exMem.linkPc;
  end

  // Writeback select
  assign wbData = wbLoad ? wbLoadData : (wbLink ? wbLinkPc : wbResult);

endmodule

// ==== hdl/cpuCore.sv ====
// Instruction and data memories live outside and answer combinationally; no interrupts, no byte access
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  word_t inst,       // Instruction at pc
  input  word_t dataRdData, // Data at dataAddr
  output word_t pc,
  output word_t dataAddr,
  output word_t dataWrData,
  output logic  dataEn,
  output logic  dataWr,
  output logic  hlt
);

  // Fetch to decode
  word_t  ifInst, ifPcNext;
  logic   ifValid;
  // Decode side
  logic   redirect, haltSeen, isBranch;
  word_t  target;
  regId_t srcA, srcB;
  // Hazard control
  logic   stall, bubble;
  flags_t flags;
  // Writeback
  logic   wbWrite;
  regId_t wbRd;
  word_t  wbData;

  decodeExecIf idEx ();  // ID/EX
  execMemIf    exMem (); // EX/MEM

  ////////////////////
  // Stages
  ////////////////////
  fetchUnit iFetch (
    .clk(clk), .rst(rst), .stall(stall), .redirect(redirect), .target(target),
    .haltSeen(haltSeen), .inst(inst), .pc(pc),
    .ifInst(ifInst), .ifPcNext(ifPcNext), .ifValid(ifValid)
  );

  decodeUnit iDecode (
    .clk(clk), .rst(rst), .bubble(bubble),
    .ifInst(ifInst), .ifPcNext(ifPcNext), .ifValid(ifValid), .flags(flags),
    .wbWrite(wbWrite), .wbRd(wbRd), .wbData(wbData),
    .redirect(redirect), .target(target), .haltSeen(haltSeen), .isBranch(isBranch),
    .srcA(srcA), .srcB(srcB), .idEx(idEx.src)
  );

  hazardUnit iHazard (
    .srcA(srcA), .srcB(srcB), .isBranch(isBranch), .ifValid(ifValid),
    .idEx(idEx.mon), .stall(stall), .bubble(bubble)
  );

  executeUnit iExecute (
    .clk(clk), .rst(rst), .wbWrite(wbWrite), .wbRd(wbRd), .wbData(wbData),
    .idEx(idEx.dst), .exMem(exMem.src), .flags(flags)
  );

  memAccessUnit iMemAccess (
    .clk(clk), .rst(rst), .dataRdData(dataRdData), .exMem(exMem.dst),
    .dataAddr(dataAddr), .dataWrData(dataWrData), .dataEn(dataEn), .dataWr(dataWr),
    .wbWrite(wbWrite), .wbRd(wbRd), .wbData(wbData), .hlt(hlt)
  );

endmodule

// ==== tb/cpuCore_tb.sv ====
// Memories modeled here answer within the cycle; programs hold at most 64 words and read as HLT beyond
`timescale 1ns/1ps

module cpuCore_tb import cpuPkg::*; ();

  localparam word_t HALT_WORD  = {OP_HLT, 12'h000};
  localparam int    WAIT_LIMIT = 200; // Cycles allowed for hlt

  logic  clk, rst, dataEn, dataWr, hlt;
  word_t inst, dataRdData, pc, dataAddr, dataWrData;

  word_t       prog [64];
  int          progLen;
  word_t       dataMem [logic [14:0]]; // Keyed by word address with a fill on a miss
  word_t       refMem [logic [14:0]];  // Reference model memory
  word_t       logAddr [$];            // Stores seen on the bus
  word_t       logData [$];
  word_t       expAddr [$];            // Stores from the reference run
  word_t       expData [$];
  logic [15:0] lfsr   = 16'd25;
  int          errors = 0;
  int          checks = 0;
  int          tests  = 0;

  cpuCore cpuCore_inst (
    .clk(clk), .rst(rst), .inst(inst), .dataRdData(dataRdData), .pc(pc),
    .dataAddr(dataAddr), .dataWrData(dataWrData), .dataEn(dataEn), .dataWr(dataWr),
    .hlt(hlt)
  );

  always #50 clk = ~clk; // 100 ns period

  // Unwritten data follows the full byte address
  function automatic word_t fillWord(logic [14:0] wordAddr);
    return ({wordAddr, 1'b0} * 16'h9E37) ^ 16'h5A5A;
  endfunction

  ////////////////////
  // Memory models
  ////////////////////
  always @(negedge clk) begin
    if (dataEn === 1'b1 && dataWr === 1'b1) begin // Store in MEM commits at the next edge
      logAddr.push_back(dataAddr);
      logData.push_back(dataWrData);
      dataMem[dataAddr[15:1]] = dataWrData;
    end
    inst = (pc[15:7] == '0) ? prog[pc[6:1]] : HALT_WORD;
    dataRdData = dataMem.exists(dataAddr[15:1]) ? dataMem[dataAddr[15:1]]
                                                : fillWord(dataAddr[15:1]);
  end

  // Galois LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsrStep(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [7:0] randomByte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]}; // One step per bit
      lfsr = lfsrStep(lfsr);
    end
    return b;
  endfunction

  ////////////////////
  // Program building
  ////////////////////
  function automatic word_t regOp(opcode_t op, regId_t rd, regId_t rs, regId_t rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic word_t immOp(opcode_t op, regId_t rd, logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  task automatic clearProgram();
    prog    = '{default: HALT_WORD};
    progLen = 0;
  endtask

  task automatic emit(word_t w);
    prog[progLen[5:0]] = w;
    progLen++;
  endtask

  // Target given as a word index in the program
  task automatic branchTo(cond_t cond, int targetIdx);
    int off;
    off = targetIdx - (progLen + 1);
    emit(immOp(OP_B, cond, off[7:0]));
  endtask

  function automatic logic condHolds(cond_t c, logic z, logic n);
    case (c)
      COND_EQ: return z;
      COND_NE: return !z;
      COND_LT: return n;
      COND_AL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  ////////////////////
  // Reference ISA model
  ////////////////////
  task automatic runReference();
    word_t   r [16];
    word_t   pcR, nextPc, ins, res, addr, imm4, imm8;
    opcode_t op;
    regId_t  rd, rs, rt;
    logic    z, n, done;
    int      steps;
    expAddr.delete();
    expData.delete();
    refMem.delete();
    r      = '{default: '0};
    pcR    = RESET_PC;
    z      = 1'b0;
    n      = 1'b0;
    done   = 1'b0;
    steps  = 0;
    while (!done && steps < 1000) begin
      ins    = (pcR[15:7] == '0) ? prog[pcR[6:1]] : HALT_WORD;
      op     = ins[15:12];
      rd     = ins[11:8];
      rs     = ins[7:4];
      rt     = ins[3:0];
      imm4   = {{12{ins[3]}}, ins[3:0]};
      imm8   = {{8{ins[7]}}, ins[7:0]};
      addr   = r[rs] + imm4;
      nextPc = pcR + 16'd2;
      res    = '0;
      case (op)
        OP_ADD:  res = r[rs] + r[rt];
        OP_SUB:  res = r[rs] - r[rt];
        OP_AND:  res = r[rs] & r[rt];
        OP_XOR:  res = r[rs] ^ r[rt];
        OP_ADDI: res = r[rs] + imm4;
        OP_LW:   res = refMem.exists(addr[15:1]) ? refMem[addr[15:1]] : fillWord(addr[15:1]);
        OP_SW: begin
          refMem[addr[15:1]] = r[rd];
          expAddr.push_back(addr);
          expData.push_back(r[rd]);
        end
        OP_LLI:  res = imm8;
        OP_B:    if (condHolds(rd, z, n)) nextPc = pcR + 16'd2 + {imm8[14:0], 1'b0};
        OP_PCS:  res = pcR + 16'd2;
        OP_HLT:  done = 1'b1;
        default: ;                                    // No-op
      endcase
      if (op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI}) z = (res == '0);
      if (op inside {OP_ADD, OP_SUB, OP_ADDI}) n = res[15];
      if (op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_LW, OP_LLI, OP_PCS} &&
          rd != '0) begin
        r[rd] = res;
      end
      pcR = nextPc;
      steps++;
    end
  endtask

  ////////////////////
  // Checks and control
  ////////////////////
  task automatic compareWord(word_t act, word_t exp, string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic compareBit(logic act, logic exp, string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s is %b, expected %b", $time, what, act, exp);
    end
  endtask

  task automatic checkStoreLog();
    compareWord(word_t'(logAddr.size()), word_t'(expAddr.size()), "store count");
    for (int i = 0; i < logAddr.size() && i < expAddr.size(); i++) begin
      compareWord(logAddr[i], expAddr[i], $sformatf("store %0d address", i));
      compareWord(logData[i], expData[i], $sformatf("store %0d data", i));
    end
  endtask

  // Holds rst for two rising edges and clears memory and log
  task automatic resetCore();
    @(negedge clk);
    rst = 1'b1;
    @(posedge clk);
    dataMem.delete();
    logAddr.delete();
    logData.delete();
    @(negedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic waitHalt(string name);
    int cycles;
    cycles = 0;
    while (hlt !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (hlt !== 1'b1) begin
      errors++;
      $display("Test %s timed out because hlt did not rise within %0d cycles", name, WAIT_LIMIT);
    end
  endtask

  task automatic finishTest(string name, int errBefore);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - errBefore);
  endtask

  ////////////////////
  // Tests
  ////////////////////
  task automatic buildArith(logic [7:0] b1, logic [7:0] b2);
    clearProgram();
    emit(immOp(OP_LLI, 4'd1, b1));
    emit(immOp(OP_LLI, 4'd2, b2));
    emit(immOp(OP_LLI, 4'd10, 8'h40));         // Store base
    emit(regOp(OP_ADD, 4'd3, 4'd1, 4'd2));
    emit(regOp(OP_SW, 4'd3, 4'd10, 4'd0));     // Data from EX/MEM
    emit(regOp(OP_SUB, 4'd4, 4'd3, 4'd1));     // r3 from MEM/WB
    emit(regOp(OP_SW, 4'd4, 4'd10, 4'd2));
    emit(regOp(OP_AND, 4'd5, 4'd4, 4'd2));
    emit(regOp(OP_SW, 4'd5, 4'd10, 4'd4));
    emit(regOp(OP_XOR, 4'd6, 4'd5, 4'd3));
    emit(regOp(OP_SW, 4'd6, 4'd10, 4'd6));
    emit(regOp(OP_ADDI, 4'd7, 4'd6, 4'hD));    // -3
    emit(regOp(OP_SW, 4'd7, 4'd10, 4'hE));     // Negative offset
    emit(regOp(OP_ADD, 4'd8, 4'd1, 4'd2));     // Gapless chain on r8
    emit(regOp(OP_SUB, 4'd8, 4'd8, 4'd1));
    emit(regOp(OP_XOR, 4'd8, 4'd8, 4'd7));
    emit(regOp(OP_ADDI, 4'd8, 4'd8, 4'd5));
    emit(regOp(OP_SW, 4'd8, 4'd10, 4'hC));
    emit(HALT_WORD);
  endtask

  task automatic arithChain();
    int errBefore;
    errBefore = errors;
    buildArith(randomByte(), randomByte());
    runReference();
    resetCore();
    waitHalt("arith");
    checkStoreLog();
    finishTest("arith", errBefore);
  endtask

  task automatic loadUse();
    int         errBefore;
    logic [7:0] b;
    word_t      v;
    errBefore = errors;
    b = randomByte();
    v = {{8{b[7]}}, b};
    clearProgram();
    emit(immOp(OP_LLI, 4'd10, 8'h60));
    emit(immOp(OP_LLI, 4'd1, b));
    emit(regOp(OP_SW, 4'd1, 4'd10, 4'd0));
    emit(regOp(OP_LW, 4'd2, 4'd10, 4'd0));
    emit(regOp(OP_ADD, 4'd3, 4'd2, 4'd2));    // Needs the stall
    emit(regOp(OP_SW, 4'd3, 4'd10, 4'd2));
    emit(regOp(OP_LW, 4'd4, 4'd10, 4'd0));
    emit(regOp(OP_SW, 4'd4, 4'd10, 4'd4));    // Load feeds store data
    emit(regOp(OP_LW, 4'd5, 4'd10, 4'd6));    // Untouched word
    emit(regOp(OP_ADDI, 4'd6, 4'd5, 4'd1));
    emit(regOp(OP_SW, 4'd6, 4'd10, 4'd6));
    emit(regOp(OP_LW, 4'd10, 4'd10, 4'd2));   // Load feeds the base
    emit(regOp(OP_SW, 4'd1, 4'd10, 4'd0));
    emit(HALT_WORD);
    runReference();
    resetCore();
    waitHalt("loadUse");
    checkStoreLog();
    if (logData.size() > 1) compareWord(logData[1], v + v, "loaded sum");
    finishTest("loadUse", errBefore);
  endtask

  task automatic branchPaths();
    int errBefore;
    errBefore = errors;
    clearProgram();
    emit(immOp(OP_LLI, 4'd10, 8'h20));        // 0
    emit(immOp(OP_LLI, 4'd11, 8'h30));
    emit(immOp(OP_LLI, 4'd12, 8'h70));        // Base of skipped stores
    emit(immOp(OP_LLI, 4'd1, 8'd5));
    emit(immOp(OP_LLI, 4'd2, 8'd5));
    emit(immOp(OP_LLI, 4'd6, 8'd9));          // 5
    emit(regOp(OP_SUB, 4'd3, 4'd1, 4'd2));    // Z set
    branchTo(COND_EQ, 9);                      // Taken
    emit(regOp(OP_SW, 4'd1, 4'd12, 4'd0));
    emit(regOp(OP_SW, 4'd3, 4'd10, 4'd0));    // 9
    branchTo(COND_NE, 12);                     // Not taken
    emit(regOp(OP_SW, 4'd2, 4'd10, 4'd2));
    emit(regOp(OP_SUB, 4'd4, 4'd1, 4'd6));    // 12 sets N
    branchTo(COND_LT, 16);                     // Taken
    emit(regOp(OP_SW, 4'd1, 4'd12, 4'd2));
    emit(regOp(OP_SW, 4'd2, 4'd12, 4'd4));
    branchTo(COND_EQ, 18);                     // 16 not taken
    emit(regOp(OP_SW, 4'd4, 4'd10, 4'd4));
    emit(regOp(OP_ADD, 4'd5, 4'd6, 4'd1));    // 18 clears Z and N
    branchTo(COND_LT, 21);                     // Not taken
    emit(regOp(OP_SW, 4'd5, 4'd10, 4'd6));
    branchTo(COND_AL, 24);                     // 21
    emit(regOp(OP_SW, 4'd1, 4'd12, 4'd6));
    emit(HALT_WORD);                           // Wrong path HLT
    emit(immOp(OP_LLI, 4'd8, 8'd3));          // 24 sets the loop count
    emit(regOp(OP_SW, 4'd8, 4'd11, 4'd0));    // 25 starts the loop body
    emit(regOp(OP_ADDI, 4'd8, 4'd8, 4'hF));
    branchTo(COND_NE, 25);                     // Backward
    emit(regOp(OP_XOR, 4'd7, 4'd1, 4'd2));    // 28 sets Z
    branchTo(COND_NE, 31);
    emit(regOp(OP_SW, 4'd7, 4'd11, 4'd2));
    emit(regOp(OP_AND, 4'd9, 4'd1, 4'd6));    // 31 clears Z
    branchTo(COND_NE, 34);
    emit(regOp(OP_SW, 4'd9, 4'd12, 4'd6));
    emit(regOp(OP_SW, 4'd9, 4'd11, 4'd4));    // 34
    emit(HALT_WORD);
    runReference();
    resetCore();
    waitHalt("branches");
    checkStoreLog();
    foreach (logAddr[i]) begin
      compareBit(logAddr[i][15:4] != 12'h007, 1'b1, $sformatf("store %0d off skipped path", i));
    end
    finishTest("branches", errBefore);
  endtask

  task automatic linkAndHalt();
    int    errBefore;
    int    storesAtHalt;
    word_t heldPc;
    errBefore = errors;
    clearProgram();
    emit(immOp(OP_LLI, 4'd10, 8'h50));
    emit(immOp(OP_PCS, 4'd1, 8'h00));         // At byte address 2
    emit(immOp(OP_LLI, 4'd2, 8'd7));          // Link reaches SW through MEM/WB
    emit(regOp(OP_SW, 4'd1, 4'd10, 4'd0));
    emit(immOp(OP_PCS, 4'd3, 8'h00));         // At byte address 8
    emit(immOp(OP_LLI, 4'd4, 8'd1));
    emit(immOp(OP_LLI, 4'd5, 8'd2));
    emit(regOp(OP_SW, 4'd3, 4'd10, 4'd2));
    emit(HALT_WORD);
    emit(regOp(OP_SW, 4'd2, 4'd10, 4'd4));    // Past HLT
    runReference();
    resetCore();
    waitHalt("linkHalt");
    checkStoreLog();
    if (logData.size() > 1) begin
      compareWord(logData[0], 16'd2 + 16'd2, "first link value");
      compareWord(logData[1], 16'd8 + 16'd2, "second link value");
    end
    heldPc       = pc;
    storesAtHalt = logAddr.size();
    repeat (10) begin
      @(negedge clk);
      compareWord(pc, heldPc, "pc after halt");
      compareBit(hlt, 1'b1, "hlt after halt");
    end
    compareWord(word_t'(logAddr.size()), word_t'(storesAtHalt), "stores after halt");
    finishTest("linkHalt", errBefore);
  endtask

  task automatic resetMidRun();
    int errBefore;
    errBefore = errors;
    buildArith(randomByte(), randomByte());
    runReference();
    resetCore();
    repeat (8) @(negedge clk);                 // Stores in flight
    rst = 1'b1;
    @(negedge clk);
    compareWord(pc, RESET_PC, "pc in reset");
    compareBit(dataEn, 1'b0, "dataEn in reset");
    resetCore();                               // Fresh memory and log before release
    waitHalt("resetRun");
    checkStoreLog();
    rst = 1'b1;                                // Reset out of the halted state
    @(negedge clk);
    compareBit(hlt, 1'b0, "hlt in reset");
    finishTest("resetRun", errBefore);
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    inst       = HALT_WORD;
    dataRdData = '0;
    arithChain();
    loadUse();
    branchPaths();
    linkAndHalt();
    resetMidRun();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/cpuPkg.sv
hdl/pipeIf.sv
hdl/fetchUnit.sv
hdl/regFile.sv
hdl/decodeUnit.sv
hdl/hazardUnit.sv
hdl/executeUnit.sv
hdl/memAccessUnit.sv
hdl/cpuCore.sv
tb/cpuCore_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then decide pass or fail from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module cpuCore_tb -f verilog.f -o cpuCore_sim

./obj_dir/cpuCore_sim > sim.log
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  echo "run.sh: testbench reported success"
  exit 0
fi
echo "run.sh: testbench reported failure"
exit 1
